/* compile.f */
chdr_pkg.sv
chdr_deframer.sv
chdr_header_queue.sv
settings_bus.sv
sample_scaler.sv
chdr_framer.sv
noc_gain_block.sv
tb_noc_gain_block.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
rm -rf obj_dir sim.log build.log
verilator --binary --assert -Wno-fatal --top-module tb_noc_gain_block -f compile.f \
   -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
echo "build or simulation ended with an error, see build.log and sim.log"
grep -qs "^SIMULATION PASSED$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_noc_gain_block.sv */
`timescale 1ns/1ns
module tb_noc_gain_block;

   localparam int SR_NEXT_DST       = 128;
   localparam int SR_CONFIG_BASE    = 129;
   localparam int CONFIG_FIFO_DEPTH = 8;
   localparam int PAYLOAD_DEPTH     = 256;
   localparam int MAX_ROWS          = 16;
   // Row programs no gain
   localparam int NO_GAIN           = -100000;

   logic        clk;
   logic        reset;
   logic        i_clear_seqnum;
   logic        i_set_stb;
   logic [7:0]  i_set_addr;
   logic [31:0] i_set_data;
   logic [63:0] i_tdata;
   logic        i_tlast;
   logic        i_tvalid;
   logic        o_tready;
   logic [63:0] o_tdata;
   logic        o_tlast;
   logic        o_tvalid;
   logic        i_out_tready;

   ////////////////////////////////////////////////////////////////////
   // Stimulus table with one row per packet
   ////////////////////////////////////////////////////////////////////
   string       name_t      [MAX_ROWS];
   logic        has_time_t  [MAX_ROWS];
   logic        eob_t       [MAX_ROWS];
   logic [63:0] ts_t        [MAX_ROWS];
   logic [15:0] src_t       [MAX_ROWS];
   logic [15:0] dst_t       [MAX_ROWS];
   int          count_t     [MAX_ROWS];
   int          gain_pre_t  [MAX_ROWS];
   int          gain_mid_t  [MAX_ROWS];
   logic [15:0] next_dst_t  [MAX_ROWS];
   int          ready_pct_t [MAX_ROWS];
   logic        clear_t     [MAX_ROWS];
   int          n_rows;

   // Reference model state and expected output words
   logic [63:0] exp_data [$];
   logic        exp_last [$];
   string       exp_name [$];
   int          model_gain;
   int          model_seq;
   logic [15:0] model_dst;
   int          seed = 32'h3634802b;
   int          ready_pct;
   logic        ready_next = 1'b1;
   int unsigned rnd;
   int          cycles = 0;
   int          words_total;
   int          timeout_limit = 0;
   logic [63:0] exp_word;
   logic        exp_end;
   string       beat_name;

   noc_gain_block #(
      .SR_NEXT_DST(SR_NEXT_DST), .SR_CONFIG_BASE(SR_CONFIG_BASE),
      .CONFIG_FIFO_DEPTH(CONFIG_FIFO_DEPTH), .PAYLOAD_DEPTH(PAYLOAD_DEPTH)
   ) i_dut (
      .clk(clk), .reset(reset), .i_clear_seqnum(i_clear_seqnum),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_tdata(i_tdata), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .o_tready(o_tready),
      .o_tdata(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid),
      .i_out_tready(i_out_tready));

   // 100 ns clock
   always #50 clk = ~clk;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic add_row(input string name, input logic ht, input logic eob,
                          input logic [63:0] ts, input logic [15:0] src,
                          input logic [15:0] dst, input int count, input int gain_pre,
                          input int gain_mid, input logic [15:0] next_dst,
                          input int pct, input logic clear);
      name_t[n_rows]      = name;
      has_time_t[n_rows]  = ht;
      eob_t[n_rows]       = eob;
      ts_t[n_rows]        = ts;
      src_t[n_rows]       = src;
      dst_t[n_rows]       = dst;
      count_t[n_rows]     = count;
      gain_pre_t[n_rows]  = gain_pre;
      gain_mid_t[n_rows]  = gain_mid;
      next_dst_t[n_rows]  = next_dst;
      ready_pct_t[n_rows] = pct;
      clear_t[n_rows]     = clear;
      n_rows++;
   endtask

   // Signed product shifted right by the fraction bits and clipped to 16 bits
   function automatic logic [15:0] apply_gain(input logic [15:0] comp, input int gain);
      int value;
      value = int'($signed(comp)) * gain;
      value = value >>> chdr_pkg::GAIN_FRAC;
      if (value > 32767)
         return 16'h7fff;
      if (value < -32768)
         return 16'h8000;
      return value[15:0];
   endfunction

   function automatic logic [31:0] scale_sample(input logic [31:0] s);
      return {apply_gain(s[31:16], model_gain), apply_gain(s[15:0], model_gain)};
   endfunction

   task automatic expect_word(input logic [63:0] data, input logic last, input string name);
      exp_data.push_back(data);
      exp_last.push_back(last);
      exp_name.push_back(name);
   endtask

   ////////////////////////////////////////////////////////////////////
   // Drivers are all called 10 ns after a rising edge
   ////////////////////////////////////////////////////////////////////
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      i_set_stb  = 1'b1;
      i_set_addr = addr;
      i_set_data = data;
      @(posedge clk);
      #10;
      i_set_stb  = 1'b0;
   endtask

   // Ready sampled on the falling edge where every input is settled
   task automatic send_word(input logic [63:0] data, input logic last);
      logic taken;
      i_tdata  = data;
      i_tlast  = last;
      i_tvalid = 1'b1;
      do begin
         @(negedge clk);
         taken = o_tready;
         @(posedge clk);
         #10;
      end while (!taken);
      i_tvalid = 1'b0;
      i_tlast  = 1'b0;
   endtask

   // Waits for the deframer header state, when earlier samples are past the queue
   task automatic wait_input_idle();
      logic idle;
      do begin
         @(negedge clk);
         idle = o_tready;
         @(posedge clk);
         #10;
      end while (!idle);
   endtask

   task automatic wait_drained();
      while (exp_data.size() != 0) begin
         @(posedge clk);
         #10;
      end
   endtask

   task automatic send_row(input int r);
      logic [31:0] samp [$];
      logic [63:0] pkt [$];
      logic [31:0] hi;
      logic [31:0] lo;
      logic [15:0] len;
      int          words;
      ready_pct = ready_pct_t[r];
      if (clear_t[r]) begin
         wait_drained();
         i_clear_seqnum = 1'b1;
         @(posedge clk);
         #10;
         i_clear_seqnum = 1'b0;
         model_seq = 0;
      end
      if (gain_pre_t[r] != NO_GAIN || next_dst_t[r] != model_dst) begin
         wait_input_idle();
         if (next_dst_t[r] != model_dst) begin
            write_setting(8'(SR_NEXT_DST), {16'h0, next_dst_t[r]});
            model_dst = next_dst_t[r];
         end
         if (gain_pre_t[r] != NO_GAIN) begin
            write_setting(8'(SR_CONFIG_BASE + 1), 32'(gain_pre_t[r]));
            model_gain = gain_pre_t[r];
         end
      end
      words = (count_t[r] + 1) / 2;
      len   = 16'(8 + (has_time_t[r] ? 8 : 0) + 4 * count_t[r]);
      for (int i = 0; i < count_t[r]; i++)
         samp.push_back($random(seed));
      // Source takes the old destination and destination takes the programmed hop
      expect_word({2'b00, has_time_t[r], eob_t[r], 12'(model_seq), len, dst_t[r], model_dst},
                  1'b0, name_t[r]);
      if (has_time_t[r])
         expect_word(ts_t[r], 1'b0, name_t[r]);
      for (int w = 0; w < words; w++) begin
         hi = samp[2*w];
         // Odd count pads the lower half
         lo = (2*w + 1 < count_t[r]) ? samp[2*w + 1] : 32'h0;
         pkt.push_back({hi, lo});
         expect_word({scale_sample(hi), scale_sample(lo)}, w == words - 1, name_t[r]);
      end
      model_seq = (model_seq + 1) % 4096;
      send_word({2'b00, has_time_t[r], eob_t[r], 12'(r), len, src_t[r], dst_t[r]}, 1'b0);
      if (has_time_t[r])
         send_word(ts_t[r], 1'b0);
      for (int w = 0; w < words; w++) begin
         send_word(pkt[w], w == words - 1);
         // Scaler is inside this packet by now
         if (w == 1 && gain_mid_t[r] != NO_GAIN)
            write_setting(8'(SR_CONFIG_BASE + 1), 32'(gain_mid_t[r]));
      end
      if (gain_mid_t[r] != NO_GAIN)
         model_gain = gain_mid_t[r];
   endtask

   ////////////////////////////////////////////////////////////////////
   // Output monitor and random back-pressure
   ////////////////////////////////////////////////////////////////////
   always @(negedge clk) begin
      if (!reset && o_tvalid && i_out_tready) begin
         assert (exp_data.size() != 0)
            else fail_run($sformatf("DUT sent word %h while no word was expected", o_tdata));
         exp_word  = exp_data.pop_front();
         exp_end   = exp_last.pop_front();
         beat_name = exp_name.pop_front();
         assert (o_tdata == exp_word)
            else fail_run($sformatf("CHECK FAILED %s tdata expected %h actual %h",
                                    beat_name, exp_word, o_tdata));
         assert (o_tlast == exp_end)
            else fail_run($sformatf("CHECK FAILED %s tlast expected %0b actual %0b",
                                    beat_name, exp_end, o_tlast));
      end
      rnd        = $random(seed);
      ready_next = (rnd % 100) < ready_pct;
   end

   initial begin
      i_out_tready = 1'b1;
      forever begin
         @(posedge clk);
         #10;
         i_out_tready = ready_next;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (timeout_limit != 0 && cycles > timeout_limit)
         fail_run($sformatf("Timeout after %0d cycles with %0d output words still missing",
                            cycles, exp_data.size()));
   end

   initial begin
      clk            = 1'b0;
      reset          = 1'b1;
      i_clear_seqnum = 1'b0;
      i_set_stb      = 1'b0;
      i_set_addr     = 8'h0;
      i_set_data     = 32'h0;
      i_tdata        = 64'h0;
      i_tlast        = 1'b0;
      i_tvalid       = 1'b0;
      ready_pct      = 100;
      model_gain     = 256;
      model_seq      = 0;
      model_dst      = 16'h0;
      n_rows         = 0;
      // name, time, eob, timestamp, src, dst, count, gain before, gain during,
      // next dst, ready percent, clear seqnum
      add_row("unity_basic", 0, 0, 64'h0, 16'h0010, 16'h0020, 8, NO_GAIN, NO_GAIN,
              16'h0101, 100, 0);
      add_row("unity_time", 1, 0, 64'h0000_0012_3456_789a, 16'h0011, 16'h0021, 9,
              NO_GAIN, NO_GAIN, 16'h0102, 100, 0);
      add_row("gain_half", 0, 0, 64'h0, 16'h0012, 16'h0022, 10, 128, NO_GAIN,
              16'h0102, 80, 0);
      add_row("gain_negate", 1, 0, 64'h0000_00ab_cdef_0001, 16'h0013, 16'h0023, 12,
              -256, 16384, 16'h0203, 70, 0);
      add_row("gain_saturate", 0, 0, 64'h0, 16'h0014, 16'h0024, 14, NO_GAIN, NO_GAIN,
              16'h0203, 100, 0);
      add_row("single_sample", 1, 0, 64'h0000_0000_0000_0777, 16'h0015, 16'h0025, 1,
              256, NO_GAIN, 16'h0304, 100, 0);
      add_row("odd_three", 0, 0, 64'h0, 16'h0016, 16'h0026, 3, NO_GAIN, NO_GAIN,
              16'h0304, 60, 0);
      add_row("full_depth", 1, 0, 64'h1111_2222_3333_4444, 16'h0017, 16'h0027,
              PAYLOAD_DEPTH, NO_GAIN, NO_GAIN, 16'h0405, 100, 0);
      add_row("backpressure", 0, 0, 64'h0, 16'h0018, 16'h0028, 40, NO_GAIN, NO_GAIN,
              16'h0405, 40, 0);
      add_row("back_to_back_a", 0, 0, 64'h0, 16'h0019, 16'h0029, 6, NO_GAIN, NO_GAIN,
              16'h0405, 60, 0);
      add_row("back_to_back_b", 1, 0, 64'h0000_5555_0000_aaaa, 16'h001a, 16'h002a, 5,
              NO_GAIN, NO_GAIN, 16'h0405, 60, 0);
      add_row("clear_eob", 0, 1, 64'h0, 16'h001b, 16'h002b, 5, NO_GAIN, NO_GAIN,
              16'h0506, 100, 1);
      add_row("after_clear", 1, 0, 64'h0000_0000_9999_0000, 16'h001c, 16'h002c, 7,
              NO_GAIN, NO_GAIN, 16'h0506, 90, 0);
      // Words in plus words out at four cycles each
      words_total = 0;
      for (int r = 0; r < n_rows; r++)
         words_total += 2 * (1 + int'(has_time_t[r]) + (count_t[r] + 1) / 2);
      timeout_limit = words_total * 4 + 200;

      repeat (4) @(posedge clk);
      #10;
      reset = 1'b0;
      for (int r = 0; r < n_rows; r++)
         send_row(r);
      wait_drained();
      // Quiet time catches stray output words
      repeat (20) @(posedge clk);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

/* noc_gain_block.sv */
`timescale 1ns/1ns
module noc_gain_block #(
   parameter int SR_NEXT_DST       = 128,
   parameter int SR_CONFIG_BASE    = 129,
   parameter int CONFIG_FIFO_DEPTH = 8,
   parameter int PAYLOAD_DEPTH     = 256
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        i_clear_seqnum,
   input  logic                        i_set_stb,
   input  logic [7:0]                  i_set_addr,
   input  logic [31:0]                 i_set_data,
   input  logic [chdr_pkg::CHDR_W-1:0] i_tdata,
   input  logic                        i_tlast,
   input  logic                        i_tvalid,
   output logic                        o_tready,
   output logic [chdr_pkg::CHDR_W-1:0] o_tdata,
   output logic                        o_tlast,
   output logic                        o_tvalid,
   input  logic                        i_out_tready
);

   // Deframer to header queue
   logic [chdr_pkg::SAMP_W-1:0] df_sample;
   logic [chdr_pkg::USER_W-1:0] df_user;
   logic                        df_last, df_valid, df_ready;
   // Header queue to scaler
   logic [chdr_pkg::SAMP_W-1:0] hq_sample;
   logic                        hq_last, hq_valid, hq_ready;
   // Scaler to framer
   logic [chdr_pkg::SAMP_W-1:0] sc_sample;
   logic                        sc_last, sc_valid, sc_ready;
   // Header handoff and settings
   logic [chdr_pkg::USER_W-1:0] hdr;
   logic                        hdr_valid, hdr_pop;
   logic [chdr_pkg::SID_W-1:0]  next_dst;
   logic [31:0]                 cfg_data;
   logic                        cfg_last, cfg_valid, cfg_ready;

   chdr_deframer u_deframer (
      .clk(clk), .reset(reset),
      .i_tdata(i_tdata), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .o_tready(o_tready),
      .o_sample(df_sample), .o_user(df_user), .o_last(df_last), .o_valid(df_valid),
      .i_ready(df_ready));

   chdr_header_queue u_header_queue (
      .clk(clk), .reset(reset), .i_next_dst(next_dst),
      .i_sample(df_sample), .i_user(df_user), .i_last(df_last), .i_valid(df_valid),
      .o_ready(df_ready), .o_sample(hq_sample), .o_last(hq_last), .o_valid(hq_valid),
      .i_ready(hq_ready), .o_hdr(hdr), .o_hdr_valid(hdr_valid), .i_hdr_pop(hdr_pop));

   settings_bus #(
      .SR_NEXT_DST(SR_NEXT_DST), .SR_CONFIG_BASE(SR_CONFIG_BASE),
      .CONFIG_FIFO_DEPTH(CONFIG_FIFO_DEPTH)
   ) u_settings_bus (
      .clk(clk), .reset(reset),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_next_dst(next_dst), .o_cfg_data(cfg_data), .o_cfg_last(cfg_last),
      .o_cfg_valid(cfg_valid), .i_cfg_ready(cfg_ready));

   sample_scaler u_scaler (
      .clk(clk), .reset(reset),
      .i_sample(hq_sample), .i_last(hq_last), .i_valid(hq_valid), .o_ready(hq_ready),
      .i_cfg_data(cfg_data), .i_cfg_last(cfg_last), .i_cfg_valid(cfg_valid),
      .o_cfg_ready(cfg_ready),
      .o_sample(sc_sample), .o_last(sc_last), .o_valid(sc_valid), .i_ready(sc_ready));

   chdr_framer #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH)) u_framer (
      .clk(clk), .reset(reset), .i_clear_seqnum(i_clear_seqnum),
      .i_sample(sc_sample), .i_last(sc_last), .i_valid(sc_valid), .o_ready(sc_ready),
      .i_hdr(hdr), .i_hdr_valid(hdr_valid), .o_hdr_pop(hdr_pop),
      .o_tdata(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid), .i_ready(i_out_tready));

endmodule

/* chdr_framer.sv */
`timescale 1ns/1ns
module chdr_framer #(
   parameter int PAYLOAD_DEPTH = 256
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        i_clear_seqnum,
   input  logic [chdr_pkg::SAMP_W-1:0] i_sample,
   input  logic                        i_last,
   input  logic                        i_valid,
   output logic                        o_ready,
   input  logic [chdr_pkg::USER_W-1:0] i_hdr,
   input  logic                        i_hdr_valid,
   output logic                        o_hdr_pop,
   output logic [chdr_pkg::CHDR_W-1:0] o_tdata,
   output logic                        o_tlast,
   output logic                        o_tvalid,
   input  logic                        i_ready
);

   localparam int AW = $clog2(PAYLOAD_DEPTH);

   chdr_pkg::frame_state_t state;
   logic [chdr_pkg::SAMP_W-1:0] mem [PAYLOAD_DEPTH];
   logic [chdr_pkg::CHDR_W-1:0] hdr_in;
   logic [chdr_pkg::CHDR_W-1:0] time_r;
   logic [chdr_pkg::SEQ_W-1:0]  seq;
   logic [AW:0]                 wr_cnt;
   logic [AW:0]                 n_samp;
   logic [AW:0]                 rd_cnt;
   logic [15:0]                 pkt_len;
   logic [chdr_pkg::SAMP_W-1:0] lo_samp;
   logic                        pay_last;
   logic                        out_xfer;

   assign hdr_in   = i_hdr[chdr_pkg::USER_W-1:chdr_pkg::CHDR_W];
   // Header plus optional time plus four bytes per sample
   assign pkt_len  = 16'd8 + (hdr_in[chdr_pkg::FLAG_HAS_TIME] ? 16'd8 : 16'd0)
                     + (16'(n_samp) << 2);
   // Odd count pads the final lower half
   assign lo_samp  = (rd_cnt + 1'b1 < n_samp) ? mem[AW'(rd_cnt + 1'b1)] : '0;
   assign pay_last = ((AW+2)'(rd_cnt) + 2 >= (AW+2)'(n_samp));

   assign o_ready   = (state == chdr_pkg::FR_COLLECT);
   assign o_tvalid  = (state == chdr_pkg::FR_HEADER) ? i_hdr_valid : (state != chdr_pkg::FR_COLLECT);
   assign o_tlast   = (state == chdr_pkg::FR_PAYLOAD) & pay_last;
   assign out_xfer  = o_tvalid & i_ready;
   assign o_hdr_pop = (state == chdr_pkg::FR_HEADER) & out_xfer;

   always_comb begin
      case (state)
         chdr_pkg::FR_HEADER:
            o_tdata = {hdr_in[chdr_pkg::FLAG_HI:chdr_pkg::FLAG_LO], seq, pkt_len,
                       hdr_in[chdr_pkg::SRC_HI:chdr_pkg::DST_LO]};
         chdr_pkg::FR_TIME:    o_tdata = time_r;
         chdr_pkg::FR_PAYLOAD: o_tdata = {mem[rd_cnt[AW-1:0]], lo_samp};
         default:              o_tdata = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= chdr_pkg::FR_COLLECT;
         seq    <= '0;
         wr_cnt <= '0;
         rd_cnt <= '0;
         n_samp <= '0;
      end else begin
         if (i_clear_seqnum)
            seq <= '0;
         else if (o_hdr_pop)
            seq <= seq + 1'b1;
         case (state)
            chdr_pkg::FR_COLLECT: begin
               if (i_valid & (wr_cnt != (AW+1)'(PAYLOAD_DEPTH)))
                  wr_cnt <= wr_cnt + 1'b1;
               if (i_valid & i_last) begin
                  n_samp <= wr_cnt + 1'b1;
                  rd_cnt <= '0;
                  state  <= chdr_pkg::FR_HEADER;
               end
            end
            chdr_pkg::FR_HEADER: begin
               if (out_xfer)
                  state <= hdr_in[chdr_pkg::FLAG_HAS_TIME] ? chdr_pkg::FR_TIME
                                                           : chdr_pkg::FR_PAYLOAD;
            end
            chdr_pkg::FR_TIME: begin
               if (out_xfer)
                  state <= chdr_pkg::FR_PAYLOAD;
            end
            default: begin
               if (out_xfer) begin
                  rd_cnt <= rd_cnt + 2'd2;
                  if (pay_last) begin
                     wr_cnt <= '0;
                     state  <= chdr_pkg::FR_COLLECT;
                  end
               end
            end
         endcase
      end
   end

   // Sample buffer and the timestamp kept after the header pop
   always_ff @(posedge clk) begin
      if (o_ready & i_valid & (wr_cnt != (AW+1)'(PAYLOAD_DEPTH)))
         mem[wr_cnt[AW-1:0]] <= i_sample;
      if (o_hdr_pop)
         time_r <= i_hdr[chdr_pkg::CHDR_W-1:0];
   end

endmodule

/* sample_scaler.sv */
`timescale 1ns/1ns
module sample_scaler (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [chdr_pkg::SAMP_W-1:0] i_sample,
   input  logic                        i_last,
   input  logic                        i_valid,
   output logic                        o_ready,
   input  logic [31:0]                 i_cfg_data,
   input  logic                        i_cfg_last,
   input  logic                        i_cfg_valid,
   output logic                        o_cfg_ready,
   output logic [chdr_pkg::SAMP_W-1:0] o_sample,
   output logic                        o_last,
   output logic                        o_valid,
   input  logic                        i_ready
);

   logic signed [15:0] gain;
   logic               in_pkt;
   logic               in_xfer;

   // Multiply, drop the fraction bits, clip to 16 bits
   function automatic logic [15:0] scale(input logic signed [15:0] x,
                                         input logic signed [15:0] g);
      logic signed [31:0] p;
      p = (x * g) >>> chdr_pkg::GAIN_FRAC;
      if (p > 32'sd32767)
         return 16'h7fff;
      else if (p < -32'sd32768)
         return 16'h8000;
      return p[15:0];
   endfunction

   // Gain only changes between packets
   assign o_cfg_ready = ~in_pkt;
   // A pending gain goes in ahead of the next first sample
   assign o_ready = (~o_valid | i_ready) & ~(~in_pkt & i_cfg_valid);
   assign in_xfer = i_valid & o_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         gain    <= 16'sd256;
         in_pkt  <= 1'b0;
         o_valid <= 1'b0;
      end else begin
         // i_cfg_last marks the end of a config group, the gain is one word
         if (i_cfg_valid & o_cfg_ready)
            gain <= i_cfg_data[15:0];
         if (in_xfer)
            in_pkt <= ~i_last;
         if (in_xfer)
            o_valid <= 1'b1;
         else if (i_ready)
            o_valid <= 1'b0;
      end
   end

   // Output stage, I in the upper half and Q in the lower
   always_ff @(posedge clk) begin
      if (in_xfer) begin
         o_sample <= {scale(i_sample[31:16], gain), scale(i_sample[15:0], gain)};
         o_last   <= i_last;
      end
   end

endmodule

/* settings_bus.sv */
`timescale 1ns/1ns
module settings_bus #(
   parameter int SR_NEXT_DST       = 128,
   parameter int SR_CONFIG_BASE    = 129,
   parameter int CONFIG_FIFO_DEPTH = 8
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       i_set_stb,
   input  logic [7:0]                 i_set_addr,
   input  logic [31:0]                i_set_data,
   output logic [chdr_pkg::SID_W-1:0] o_next_dst,
   output logic [31:0]                o_cfg_data,
   output logic                       o_cfg_last,
   output logic                       o_cfg_valid,
   input  logic                       i_cfg_ready
);

   localparam int AW = $clog2(CONFIG_FIFO_DEPTH);

   logic [32:0]   fifo [CONFIG_FIFO_DEPTH];
   logic [AW-1:0] wr_idx;
   logic [AW-1:0] rd_idx;
   logic [AW:0]   count;
   logic          cfg_hit;
   logic          cfg_last;
   logic          push;
   logic          pop;

   ////////////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////////////
   assign cfg_last = (i_set_addr == 8'(SR_CONFIG_BASE + 1));
   assign cfg_hit  = (i_set_addr == 8'(SR_CONFIG_BASE)) | cfg_last;
   // Writes into a full FIFO are lost, the bus has no back-pressure
   assign push = i_set_stb & cfg_hit & (count != (AW+1)'(CONFIG_FIFO_DEPTH));
   assign pop  = o_cfg_valid & i_cfg_ready;

   assign o_cfg_valid = (count != '0);
   assign {o_cfg_last, o_cfg_data} = fifo[rd_idx];

   always_ff @(posedge clk) begin
      if (reset) begin
         o_next_dst <= '0;
         wr_idx     <= '0;
         rd_idx     <= '0;
         count      <= '0;
      end else begin
         if (i_set_stb && i_set_addr == 8'(SR_NEXT_DST))
            o_next_dst <= i_set_data[chdr_pkg::SID_W-1:0];
         if (push)
            wr_idx <= (wr_idx == AW'(CONFIG_FIFO_DEPTH - 1)) ? '0 : wr_idx + 1'b1;
         if (pop)
            rd_idx <= (rd_idx == AW'(CONFIG_FIFO_DEPTH - 1)) ? '0 : rd_idx + 1'b1;
         if (push & ~pop)
            count <= count + 1'b1;
         else if (pop & ~push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         fifo[wr_idx] <= {cfg_last, i_set_data};
   end

endmodule

/* chdr_header_queue.sv */
`timescale 1ns/1ns
module chdr_header_queue (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [chdr_pkg::SID_W-1:0]  i_next_dst,
   input  logic [chdr_pkg::SAMP_W-1:0] i_sample,
   input  logic [chdr_pkg::USER_W-1:0] i_user,
   input  logic                        i_last,
   input  logic                        i_valid,
   output logic                        o_ready,
   output logic [chdr_pkg::SAMP_W-1:0] o_sample,
   output logic                        o_last,
   output logic                        o_valid,
   input  logic                        i_ready,
   output logic [chdr_pkg::USER_W-1:0] o_hdr,
   output logic                        o_hdr_valid,
   input  logic                        i_hdr_pop
);

   logic [chdr_pkg::USER_W-1:0] mem [4];
   logic [chdr_pkg::CHDR_W-1:0] hdr_in;
   logic [chdr_pkg::USER_W-1:0] new_hdr;
   // Pointers carry one wrap bit over the 2-bit index
   logic [2:0] wr_ptr;
   logic [2:0] rd_ptr;
   logic       sof;
   logic       full;
   logic       stall;
   logic       push;

   assign hdr_in = i_user[chdr_pkg::USER_W-1:chdr_pkg::CHDR_W];
   // Old destination becomes the source, the register gives the next hop
   assign new_hdr = {hdr_in[chdr_pkg::CHDR_W-1:chdr_pkg::SID_W*2],
                     hdr_in[chdr_pkg::DST_HI:chdr_pkg::DST_LO], i_next_dst,
                     i_user[chdr_pkg::CHDR_W-1:0]};

   assign full  = (wr_ptr[1:0] == rd_ptr[1:0]) && (wr_ptr[2] != rd_ptr[2]);
   // First beat waits for a free entry
   assign stall = sof & full;
   assign push  = sof & i_valid & i_ready & ~full;

   assign o_ready     = i_ready & ~stall;
   assign o_valid     = i_valid & ~stall;
   assign o_sample    = i_sample;
   assign o_last      = i_last;
   assign o_hdr       = mem[rd_ptr[1:0]];
   assign o_hdr_valid = (wr_ptr != rd_ptr);

   always_ff @(posedge clk) begin
      if (reset) begin
         sof    <= 1'b1;
         wr_ptr <= 3'd0;
         rd_ptr <= 3'd0;
      end else begin
         if (o_valid & i_ready)
            sof <= i_last;
         if (push)
            wr_ptr <= wr_ptr + 3'd1;
         if (i_hdr_pop & o_hdr_valid)
            rd_ptr <= rd_ptr + 3'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr[1:0]] <= new_hdr;
   end

endmodule

/* chdr_deframer.sv */
`timescale 1ns/1ns
module chdr_deframer (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [chdr_pkg::CHDR_W-1:0] i_tdata,
   input  logic                        i_tlast,
   input  logic                        i_tvalid,
   output logic                        o_tready,
   output logic [chdr_pkg::SAMP_W-1:0] o_sample,
   output logic [chdr_pkg::USER_W-1:0] o_user,
   output logic                        o_last,
   output logic                        o_valid,
   input  logic                        i_ready
);

   chdr_pkg::deframe_state_t state;
   logic [chdr_pkg::CHDR_W-1:0] hdr_r;
   logic [chdr_pkg::CHDR_W-1:0] time_r;
   logic [chdr_pkg::CHDR_W-1:0] word_r;
   logic                        word_valid;
   logic                        word_last;
   // Low when the upper sample of word_r is on the output
   logic                        half;
   // Samples still to send in this packet, zero means drop words until tlast
   logic [15:0]                 rem;
   logic [15:0]                 hdr_samples;
   logic                        in_xfer;
   logic                        out_xfer;

   // Bytes after the header and optional time, four per sample
   assign hdr_samples = (i_tdata[chdr_pkg::LEN_HI:chdr_pkg::LEN_LO] - 16'd8
                         - (i_tdata[chdr_pkg::FLAG_HAS_TIME] ? 16'd8 : 16'd0)) >> 2;

   assign in_xfer  = i_tvalid & o_tready;
   assign out_xfer = o_valid & i_ready;

   assign o_valid  = word_valid;
   assign o_sample = half ? word_r[chdr_pkg::SAMP_W-1:0] : word_r[chdr_pkg::CHDR_W-1:chdr_pkg::SAMP_W];
   assign o_user   = {hdr_r, time_r};
   // Length count ends the packet, input tlast cuts it short
   assign o_last   = (rem == 16'd1) | (half & word_last);

   always_comb begin
      if (state != chdr_pkg::DF_PAYLOAD) begin
         o_tready = 1'b1;
      end else begin
         // New word once the lower half leaves, never past the packet end
         o_tready = (rem == 16'd0) | ~word_valid | (half & i_ready & ~o_last);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= chdr_pkg::DF_HEADER;
         word_valid <= 1'b0;
         word_last  <= 1'b0;
         half       <= 1'b0;
         rem        <= 16'd0;
      end else begin
         case (state)
            chdr_pkg::DF_HEADER: begin
               if (in_xfer) begin
                  rem <= hdr_samples;
                  if (i_tlast)
                     state <= chdr_pkg::DF_HEADER;
                  else if (i_tdata[chdr_pkg::FLAG_HAS_TIME])
                     state <= chdr_pkg::DF_TIME;
                  else
                     state <= chdr_pkg::DF_PAYLOAD;
               end
            end
            chdr_pkg::DF_TIME: begin
               if (in_xfer)
                  state <= i_tlast ? chdr_pkg::DF_HEADER : chdr_pkg::DF_PAYLOAD;
            end
            default: begin
               if (out_xfer) begin
                  half <= ~half;
                  rem  <= o_last ? 16'd0 : rem - 16'd1;
                  if (half | o_last)
                     word_valid <= 1'b0;
                  if (o_last & word_last)
                     state <= chdr_pkg::DF_HEADER;
               end
               if (in_xfer) begin
                  if (rem == 16'd0) begin
                     // Resync on the input tlast
                     if (i_tlast)
                        state <= chdr_pkg::DF_HEADER;
                  end else begin
                     word_valid <= 1'b1;
                     word_last  <= i_tlast;
                     half       <= 1'b0;
                  end
               end
            end
         endcase
      end
   end

   // Header, time and payload word holding registers
   always_ff @(posedge clk) begin
      if (in_xfer && state == chdr_pkg::DF_HEADER) begin
         hdr_r  <= i_tdata;
         time_r <= '0;
      end
      if (in_xfer && state == chdr_pkg::DF_TIME)
         time_r <= i_tdata;
      if (in_xfer && state == chdr_pkg::DF_PAYLOAD)
         word_r <= i_tdata;
   end

endmodule

/* chdr_pkg.sv */
package chdr_pkg;

   // Bus and sample widths
   localparam int CHDR_W = 64;
   localparam int SAMP_W = 32;
   // Side information is the header over the timestamp
   localparam int USER_W = 128;
   localparam int SEQ_W = 12;
   localparam int SID_W = 16;

   // Gain is fixed point with 8 fraction bits, 256 is unity
   localparam int GAIN_FRAC = 8;

   ////////////////////////////////////////////////////////////////////
   // CHDR header field positions
   ////////////////////////////////////////////////////////////////////
   localparam int FLAG_HI = 63;
   localparam int FLAG_LO = 60;
   localparam int SEQ_HI = 59;
   localparam int SEQ_LO = 48;
   localparam int LEN_HI = 47;
   localparam int LEN_LO = 32;
   localparam int SRC_HI = 31;
   localparam int SRC_LO = 16;
   localparam int DST_HI = 15;
   localparam int DST_LO = 0;

   // Single bit flags inside the flag nibble
   typedef enum int {
      FLAG_EOB      = 60,
      FLAG_HAS_TIME = 61
   } chdr_flag_t;

   // Input side walks header, optional time, then payload words
   typedef enum logic [1:0] {DF_HEADER, DF_TIME, DF_PAYLOAD} deframe_state_t;

   // Output side first collects a packet, then mirrors the input order
   typedef enum logic [1:0] {FR_COLLECT, FR_HEADER, FR_TIME, FR_PAYLOAD} frame_state_t;

endpackage
